//--- rtl/trigger_pkg.sv
`default_nettype none

package trigger_pkg;

    localparam int bus_addr_w = 16;
    typedef logic [7:0] bus_byte_t;

    localparam int n_trig_inputs = 8;
    typedef logic [n_trig_inputs-1:0] trig_lines_t;

    typedef logic [31:0] trig_count_t;

    // trigger word: marker on top, counter value below it
    typedef logic [31:0] trig_word_t;
    localparam int trig_marker_bit = 31;

    localparam int fifo_depth = 8;
    localparam int fifo_ptr_w = 3;

    localparam bus_byte_t version = 8'd10;
    localparam bus_byte_t reg_rst_value = 8'h00;

    // register map
    localparam int addr_soft_rst = 0;
    localparam int addr_conf = 1;
    localparam int addr_cnt_b0 = 8;
    localparam int addr_cnt_b1 = 9;
    localparam int addr_cnt_b2 = 10;
    localparam int addr_cnt_b3 = 11;      // write here loads the counter
    localparam int addr_lost = 12;
    localparam int addr_trig_sel_b0 = 13; // first stored config byte
    localparam int addr_veto_sel_b0 = 17;
    localparam int addr_trig_inv_b0 = 21;
    localparam int addr_count_max_lo = 25;
    localparam int addr_cfg_last = 28;    // top byte of count max
    localparam int reg_count = 34;

    localparam int n_cfg_regs = addr_cfg_last - addr_trig_sel_b0 + 1;
    localparam int cfg_idx_w = $clog2(n_cfg_regs);
    localparam int conf_enable_bit = 3;

    typedef enum logic [1:0] {idle, wait_ack, wait_low} trig_state_e;

endpackage

`default_nettype wire

//--- rtl/trigger_conf_if.sv
`default_nettype none

// config and counter preload from the register bank to the trigger path
interface trigger_conf_if;
    import trigger_pkg::*;

    trig_lines_t trig_select;
    trig_lines_t veto_select;
    trig_lines_t trig_invert;
    logic        conf_enable;
    trig_count_t count_max;       // 0 means no limit
    logic        count_set;       // one cycle after a write to addr 11
    trig_count_t count_set_value;

    modport regs (output trig_select, veto_select, trig_invert, conf_enable,
                  count_max, count_set, count_set_value);
    modport core (input trig_select, veto_select, trig_invert, conf_enable,
                  count_max, count_set, count_set_value);

endinterface

`default_nettype wire

//--- rtl/trigger_regs.sv
`default_nettype none

module trigger_regs (
    input  wire                               bus_clk,
    input  wire                               rst,
    input  wire [trigger_pkg::bus_addr_w-1:0] bus_add,
    input  wire trigger_pkg::bus_byte_t       bus_data_in,
    input  wire                               bus_rd,
    input  wire                               bus_wr,
    output trigger_pkg::bus_byte_t            bus_data_out,
    input  wire trigger_pkg::trig_count_t     trig_count,
    input  wire trigger_pkg::bus_byte_t       lost_count,
    output logic                              soft_rst,
    trigger_conf_if.regs                      conf
);
    import trigger_pkg::*;

    bus_byte_t             cfg_mem [n_cfg_regs]; // addresses 13 to 28
    bus_byte_t             cnt_pre [4];          // preload bytes, addresses 8 to 11
    logic                  conf_enable;
    bus_byte_t             conf_byte;
    logic [31:8]           cnt_buf;              // bytes 1 to 3, taken on a read of addr 8
    int                    addr_i;
    logic [cfg_idx_w-1:0]  cfg_off;
    logic                  cfg_hit;
    logic                  clr;

    function automatic logic [cfg_idx_w-1:0] cfg_idx(int a);
        return cfg_idx_w'(a - addr_trig_sel_b0);
    endfunction

    assign addr_i = int'(bus_add);
    assign cfg_off = cfg_idx(addr_i);
    assign cfg_hit = (addr_i >= addr_trig_sel_b0) && (addr_i <= addr_cfg_last);

    // write to address 0 resets the whole core
    assign soft_rst = bus_wr && (addr_i == addr_soft_rst);
    assign clr = rst || soft_rst;

    always_ff @(posedge bus_clk)
    begin
        if (clr)
        begin
            conf_enable <= 1'b0;
            for (int i = 0; i < n_cfg_regs; i++)
                cfg_mem[i] <= reg_rst_value;
            for (int i = 0; i < 4; i++)
                cnt_pre[i] <= reg_rst_value;
        end
        else if (bus_wr && addr_i < reg_count)
        begin
            if (addr_i == addr_conf)
                conf_enable <= bus_data_in[conf_enable_bit]; // other bits dropped
            if (addr_i >= addr_cnt_b0 && addr_i <= addr_cnt_b3)
                cnt_pre[bus_add[1:0]] <= bus_data_in;
            if (cfg_hit)
                cfg_mem[cfg_off] <= bus_data_in;
        end
    end

    // preload strobe follows the write of the top byte
    always_ff @(posedge bus_clk)
    begin
        if (clr)
            conf.count_set <= 1'b0;
        else
            conf.count_set <= bus_wr && (addr_i == addr_cnt_b3);
    end

    always_ff @(posedge bus_clk)
    begin
        if (clr)
            cnt_buf <= '0;
        else if (bus_rd && addr_i == addr_cnt_b0)
            cnt_buf <= trig_count[31:8];
    end

    always_comb
    begin
        conf_byte = '0;
        conf_byte[conf_enable_bit] = conf_enable;
    end

    always_ff @(posedge bus_clk)
    begin
        if (rst)
            bus_data_out <= '0;
        else if (bus_rd)
        begin
            case (addr_i)
                addr_soft_rst: bus_data_out <= version;
                addr_conf:     bus_data_out <= conf_byte;
                addr_cnt_b0:   bus_data_out <= trig_count[7:0]; // live byte
                addr_cnt_b1:   bus_data_out <= cnt_buf[15:8];
                addr_cnt_b2:   bus_data_out <= cnt_buf[23:16];
                addr_cnt_b3:   bus_data_out <= cnt_buf[31:24];
                addr_lost:     bus_data_out <= lost_count;
                default:       bus_data_out <= cfg_hit ? cfg_mem[cfg_off] : '0;
            endcase
        end
    end

    assign conf.conf_enable = conf_enable;
    assign conf.trig_select = cfg_mem[cfg_idx(addr_trig_sel_b0)];
    assign conf.veto_select = cfg_mem[cfg_idx(addr_veto_sel_b0)];
    assign conf.trig_invert = cfg_mem[cfg_idx(addr_trig_inv_b0)];
    assign conf.count_max = {cfg_mem[cfg_idx(addr_count_max_lo + 3)],
                             cfg_mem[cfg_idx(addr_count_max_lo + 2)],
                             cfg_mem[cfg_idx(addr_count_max_lo + 1)],
                             cfg_mem[cfg_idx(addr_count_max_lo)]};
    assign conf.count_set_value = {cnt_pre[3], cnt_pre[2], cnt_pre[1], cnt_pre[0]};

endmodule

`default_nettype wire

//--- rtl/trigger_input.sv
`default_nettype none

module trigger_input (
    input  wire                           bus_clk,
    input  wire                           rst,
    input  wire                           soft_rst,
    input  wire trigger_pkg::trig_lines_t trigger,
    input  wire trigger_pkg::trig_lines_t trigger_veto,
    trigger_conf_if.core                  conf,
    output logic                          trig_pulse,
    output logic                          trig_level,
    output logic                          veto_level
);
    import trigger_pkg::*;

    trig_lines_t trig_xor_inv;
    logic        trig_or;
    logic        veto_or;
    logic [1:0]  trig_sync;
    logic [1:0]  veto_sync;
    logic        trig_last;   // edge flop

    // invert first, then mask with the select bits
    assign trig_xor_inv = trigger ^ conf.trig_invert;
    assign trig_or = |(trig_xor_inv & conf.trig_select);
    assign veto_or = |(trigger_veto & conf.veto_select); // veto lines are never inverted

    always_ff @(posedge bus_clk)
    begin
        if (rst || soft_rst)
        begin
            trig_sync <= '0;
            veto_sync <= '0;
            trig_last <= 1'b0;
        end
        else
        begin
            trig_sync <= {trig_sync[0], trig_or};
            veto_sync <= {veto_sync[0], veto_or};
            trig_last <= trig_sync[1];
        end
    end

    assign trig_level = trig_sync[1];
    assign trig_pulse = trig_sync[1] & ~trig_last; // rising edge only
    assign veto_level = veto_sync[1];

endmodule

`default_nettype wire

//--- rtl/trigger_fsm.sv
`default_nettype none

module trigger_fsm (
    input  wire                       bus_clk,
    input  wire                       rst,
    input  wire                       soft_rst,
    trigger_conf_if.core              conf,
    input  wire                       trig_pulse,
    input  wire                       trig_level,
    input  wire                       veto_level,
    input  wire                       ext_trigger_enable,
    input  wire                       trigger_acknowledge,
    output logic                      trigger_accepted_flag,
    output logic                      trigger_enabled,
    output trigger_pkg::trig_count_t  trig_count,
    output logic                      word_write,
    output trigger_pkg::trig_word_t   word_data
);
    import trigger_pkg::*;

    trig_state_e state;
    logic        limit;
    logic        accept;

    // max of zero disables the limit
    assign limit = (conf.count_max != '0) && (trig_count >= conf.count_max);
    assign accept = (state == idle) && trig_pulse && trigger_enabled && !veto_level;

    always_ff @(posedge bus_clk)
    begin
        if (rst || soft_rst)
            trigger_enabled <= 1'b0;
        else
            trigger_enabled <= (conf.conf_enable || ext_trigger_enable) && !limit;
    end

    always_ff @(posedge bus_clk)
    begin
        if (rst || soft_rst)
        begin
            state <= idle;
            trigger_accepted_flag <= 1'b0;
            word_write <= 1'b0;
        end
        else
        begin
            trigger_accepted_flag <= accept;
            word_write <= accept;
            case (state)
                idle:
                    if (accept)
                        state <= ext_trigger_enable ? wait_ack : wait_low;
                wait_ack:
                    if (trigger_acknowledge)
                        state <= idle;
                wait_low:
                    if (!trig_level)
                        state <= idle; // new edge needed before the next trigger
                default:
                    state <= idle;
            endcase
        end
    end

    // software preload wins over a trigger in the same cycle
    always_ff @(posedge bus_clk)
    begin
        if (rst || soft_rst)
            trig_count <= '0;
        else if (conf.count_set)
            trig_count <= conf.count_set_value;
        else if (accept)
            trig_count <= trig_count + trig_count_t'(1);
    end

    always_ff @(posedge bus_clk)
    begin
        if (accept)
        begin
            word_data[trig_marker_bit] <= 1'b1;
            word_data[trig_marker_bit-1:0] <= trig_count[trig_marker_bit-1:0]; // pre-increment
        end
    end

endmodule

`default_nettype wire

//--- rtl/trigger_fifo.sv
`default_nettype none

module trigger_fifo (
    input  wire                          bus_clk,
    input  wire                          rst,
    input  wire                          soft_rst,
    input  wire                          word_write,
    input  wire trigger_pkg::trig_word_t word_data,
    input  wire                          fifo_read,
    output logic                         fifo_empty,
    output trigger_pkg::trig_word_t      fifo_data,
    output trigger_pkg::bus_byte_t       lost_count
);
    import trigger_pkg::*;

    trig_word_t            mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_ptr_w:0]   fill;
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full = (fill == (fifo_ptr_w+1)'(fifo_depth));
    assign fifo_empty = (fill == '0);
    assign push = word_write && !full;
    assign pop = fifo_read && !fifo_empty;
    assign fifo_data = mem[rd_ptr]; // head shows without a read

    always_ff @(posedge bus_clk)
    begin
        if (push)
            mem[wr_ptr] <= word_data;
    end

    always_ff @(posedge bus_clk)
    begin
        if (rst || soft_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
            lost_count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + fifo_ptr_w'(1);  // wraps, depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + fifo_ptr_w'(1);
            if (push && !pop)
                fill <= fill + (fifo_ptr_w+1)'(1);
            else if (pop && !push)
                fill <= fill - (fifo_ptr_w+1)'(1);
            if (word_write && full && lost_count != '1)
                lost_count <= lost_count + 8'd1; // sticks at 255
        end
    end

endmodule

`default_nettype wire

//--- rtl/trigger_controller.sv
`default_nettype none

module trigger_controller (
    input  wire                               bus_clk,
    input  wire                               rst,
    input  wire [trigger_pkg::bus_addr_w-1:0] bus_add,
    input  wire trigger_pkg::bus_byte_t       bus_data_in,
    input  wire                               bus_rd,
    input  wire                               bus_wr,
    output wire trigger_pkg::bus_byte_t       bus_data_out,
    input  wire                               fifo_read,
    output wire                               fifo_empty,
    output wire trigger_pkg::trig_word_t      fifo_data,
    input  wire trigger_pkg::trig_lines_t     trigger,
    input  wire trigger_pkg::trig_lines_t     trigger_veto,
    input  wire                               ext_trigger_enable,
    input  wire                               trigger_acknowledge,
    output wire                               trigger_accepted_flag,
    output wire                               trigger_enabled
);
    import trigger_pkg::*;

    wire         soft_rst;
    wire         trig_pulse;
    wire         trig_level;
    wire         veto_level;
    wire         word_write;
    trig_word_t  word_data;
    trig_count_t trig_count;
    bus_byte_t   lost_count;

    trigger_conf_if conf_if ();

    trigger_regs regs_i (
        .bus_clk(bus_clk), .rst(rst),
        .bus_add(bus_add), .bus_data_in(bus_data_in),
        .bus_rd(bus_rd), .bus_wr(bus_wr), .bus_data_out(bus_data_out),
        .trig_count(trig_count), .lost_count(lost_count),
        .soft_rst(soft_rst), .conf(conf_if.regs)
    );

    trigger_input input_i (
        .bus_clk(bus_clk), .rst(rst), .soft_rst(soft_rst),
        .trigger(trigger), .trigger_veto(trigger_veto), .conf(conf_if.core),
        .trig_pulse(trig_pulse), .trig_level(trig_level), .veto_level(veto_level)
    );

    trigger_fsm fsm_i (
        .bus_clk(bus_clk), .rst(rst), .soft_rst(soft_rst), .conf(conf_if.core),
        .trig_pulse(trig_pulse), .trig_level(trig_level), .veto_level(veto_level),
        .ext_trigger_enable(ext_trigger_enable),
        .trigger_acknowledge(trigger_acknowledge),
        .trigger_accepted_flag(trigger_accepted_flag),
        .trigger_enabled(trigger_enabled), .trig_count(trig_count),
        .word_write(word_write), .word_data(word_data)
    );

    trigger_fifo fifo_i (
        .bus_clk(bus_clk), .rst(rst), .soft_rst(soft_rst),
        .word_write(word_write), .word_data(word_data),
        .fifo_read(fifo_read), .fifo_empty(fifo_empty),
        .fifo_data(fifo_data), .lost_count(lost_count)
    );

endmodule

`default_nettype wire

//--- test/trigger_controller_sva.sv
`default_nettype none

module trigger_controller_sva (
    input wire bus_clk,
    input wire rst,
    input wire trigger_accepted_flag,
    input wire trigger_enabled,
    input wire fifo_empty
);

    // FSM leaves idle on every accept
    accept_single_cycle: assert property (@(posedge bus_clk) disable iff (rst)
        trigger_accepted_flag |=> !trigger_accepted_flag)
        else $error("trigger_accepted_flag high for two cycles");

    empty_after_reset: assert property (@(posedge bus_clk) rst |=> fifo_empty)
        else $error("fifo_empty low in the cycle after reset");

    // enable is sampled in the accept cycle
    accept_only_enabled: assert property (@(posedge bus_clk) disable iff (rst)
        $rose(trigger_accepted_flag) |-> $past(trigger_enabled))
        else $error("trigger accepted while trigger_enabled was low");

endmodule

bind trigger_controller trigger_controller_sva sva_i (
    .bus_clk(bus_clk), .rst(rst), .trigger_accepted_flag(trigger_accepted_flag),
    .trigger_enabled(trigger_enabled), .fifo_empty(fifo_empty)
);

`default_nettype wire

//--- test/tb_trigger_controller.sv
`default_nettype none

module tb_trigger_controller;
    import trigger_pkg::*;

    localparam int clk_period = 8;
    localparam int rst_cycles = 16;
    localparam int cycles_per_line = 40;

    logic                  bus_clk;
    logic                  rst;
    logic [bus_addr_w-1:0] bus_add;
    bus_byte_t             bus_data_in;
    logic                  bus_rd;
    logic                  bus_wr;
    bus_byte_t             bus_data_out;
    logic                  fifo_read;
    logic                  fifo_empty;
    trig_word_t            fifo_data;
    trig_lines_t           trigger;
    trig_lines_t           trigger_veto;
    logic                  ext_trigger_enable;
    logic                  trigger_acknowledge;
    logic                  trigger_accepted_flag;
    logic                  trigger_enabled;

    int seed = 32'hc752b3b8;
    int cycles = 0;
    int cycle_limit = 0;   // armed once the trace is counted
    int errors = 0;
    int test_errors = 0;
    int tests = 0;
    int failed_tests = 0;
    logic [31:0] preload = '0;      // counter bytes written at 8 to 11
    logic [31:0] count_model = '0;  // preload plus accept flags seen

    trigger_controller dut (.*);

    initial
    begin
        bus_clk = 1'b0;
        forever #(clk_period / 2) bus_clk = ~bus_clk;
    end

    always @(posedge bus_clk)
    begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("timeout: simulation did not finish");
            $display("Testbench failed");
            $finish;
        end
    end

    // one flag per accepted trigger, sampled away from the edge
    always @(negedge bus_clk)
    begin
        if (trigger_accepted_flag)
            count_model++;
    end

    // all stimulus changes 1 unit after the rising edge
    task automatic next_cycle();
        @(posedge bus_clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual)
        else
        begin
            $display("[FAIL] %0t %0s: expected %0h, got %0h", $time, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    // soft reset clears the counter, a write to the top byte loads it
    task automatic track_count_write(input int addr, input int data);
        if (addr == addr_soft_rst)
        begin
            preload = '0;
            count_model = '0;
        end
        else if (addr >= addr_cnt_b0 && addr <= addr_cnt_b3)
        begin
            preload[8*(addr-addr_cnt_b0) +: 8] = 8'(data);
            if (addr == addr_cnt_b3)
                count_model = preload;
        end
    endtask

    task automatic bus_write(input int addr, input int data);
        bus_add = bus_addr_w'(addr);
        bus_data_in = 8'(data);
        bus_wr = 1'b1;
        next_cycle();
        bus_wr = 1'b0;
        track_count_write(addr, data);
    endtask

    task automatic bus_read(input int addr, input int expected);
        bus_add = bus_addr_w'(addr);
        bus_rd = 1'b1;
        next_cycle();   // data registered at this edge
        bus_rd = 1'b0;
        check_value($sformatf("read addr %0d", addr), expected, 32'(bus_data_out));
        if (addr == addr_cnt_b0)
            check_value("accept flags since preload", expected, 32'(count_model[7:0]));
    endtask

    task automatic pulse_lines(input int lines, input int count);
        repeat (count)
        begin
            trigger = trig_lines_t'(lines);
            repeat (6) next_cycle();
            trigger = '0;
            repeat (6) next_cycle();
        end
    endtask

    // words of back to back triggers carry consecutive counter values
    task automatic pop_words(input logic [31:0] first, input int count);
        for (int i = 0; i < count; i++)
        begin
            check_value($sformatf("fifo_empty before pop %0d", i), 0, 32'(fifo_empty));
            check_value($sformatf("fifo word %0d", i), first + 32'(i), fifo_data);
            fifo_read = 1'b1;
            next_cycle();
            fifo_read = 1'b0;
        end
    endtask

    task automatic end_test(input logic [8*32-1:0] name);
        tests++;
        if (test_errors == 0)
            $display("test %0s: ok", name);
        else
        begin
            failed_tests++;
            $display("test %0s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial
    begin
        int               fd;
        int               n;
        int               a;
        int               b;
        logic [31:0]      word;
        logic [7:0]       cmd;
        logic [8*32-1:0]  name;
        logic [8*256-1:0] line;

        bus_add = '0;
        bus_data_in = '0;
        bus_rd = 1'b0;
        bus_wr = 1'b0;
        fifo_read = 1'b0;
        trigger = '0;
        trigger_veto = '0;
        ext_trigger_enable = 1'b0;
        trigger_acknowledge = 1'b0;
        rst = 1'b1;
        fd = $fopen("test/trigger_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file test/trigger_trace.txt");
            errors++;
        end
        else
        begin
            n = 0;
            while ($fgets(line, fd) != 0)
                n++;
            $fclose(fd);
            cycle_limit = n * cycles_per_line + 500;
            fd = $fopen("test/trigger_trace.txt", "r");
            repeat (rst_cycles) @(posedge bus_clk);
            #1;
            rst = 1'b0;
            next_cycle();
            while (!$feof(fd))
            begin
                if ($fscanf(fd, " %c", cmd) != 1)
                    break;
                case (cmd)
                    "#": n = $fgets(line, fd);   // comment to end of line
                    "W":
                    begin
                        n = $fscanf(fd, "%d %h", a, b);
                        bus_write(a, b);
                    end
                    "R":
                    begin
                        n = $fscanf(fd, "%d %h", a, b);
                        bus_read(a, b);
                    end
                    "P":
                    begin
                        n = $fscanf(fd, "%h %d", a, b);
                        pulse_lines(a, b);
                    end
                    "V":
                    begin
                        n = $fscanf(fd, "%h", a);
                        trigger_veto = trig_lines_t'(a);
                        next_cycle();
                    end
                    "E":
                    begin
                        n = $fscanf(fd, "%d", a);
                        ext_trigger_enable = a[0];
                        next_cycle();
                    end
                    "K":
                    begin
                        trigger_acknowledge = 1'b1;
                        repeat (2) next_cycle();
                        trigger_acknowledge = 1'b0;
                    end
                    "F":
                    begin
                        n = $fscanf(fd, "%h %d", word, a);
                        pop_words(word, a);
                    end
                    "S":
                    begin
                        n = $fscanf(fd, "%d %d", a, b);
                        check_value("trigger_enabled", a, 32'(trigger_enabled));
                        check_value("fifo_empty", b, 32'(fifo_empty));
                    end
                    "X":
                    begin
                        name = '0;
                        n = $fscanf(fd, "%s", name);
                        end_test(name);
                    end
                    default:
                    begin
                        $display("unknown trace command '%c'", cmd);
                        errors++;
                    end
                endcase
                if (cmd != "#")
                    repeat (int'($unsigned($random(seed)) % 4)) next_cycle(); // idle gap
            end
            $fclose(fd);
        end
        $display("%0d tests run, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0 && tests > 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/trigger_trace.txt
# cmd args: W addr data, R addr expected, P lines repeats, V lines, E bit, K (2-cycle ack)
# F first_word count, S enabled empty, X test_name; addr, repeats, counts decimal, rest hex
R 0 0a    # version
W 13 5a
W 25 34
R 13 5a
R 25 34
R 30 00   # dropped register
W 0 00    # soft reset
R 13 00
X reset_readback
W 1 08
W 13 01
P 02 1    # unselected line
P 01 2
W 21 02
W 13 03   # inverted line 1 goes high, counts
R 0 0a
P 02 1    # line 1 dropped and back, counts
R 8 04
X select_invert
W 0 00
W 1 08
W 13 01
W 17 02
V 01      # unselected veto
P 01 1
V 02
P 01 1    # vetoed
R 8 01
X veto
W 0 00
W 1 08
W 13 01
W 8 05
W 11 00   # preload 5
W 25 07
P 01 3    # third one over the limit
R 8 07
F 80000005 2
S 0 1
X limit_preload
W 0 00
W 1 08
W 13 01
P 01 10
F 80000000 8
S 1 1
R 12 02   # two words lost
X fifo_overflow
E 1
P 01 1
P 01 1    # waiting for ack
K
P 01 1
R 8 0c
F 8000000a 2
X ext_ack

//--- tb.f
rtl/trigger_pkg.sv
rtl/trigger_conf_if.sv
rtl/trigger_regs.sv
rtl/trigger_input.sv
rtl/trigger_fsm.sv
rtl/trigger_fifo.sv
rtl/trigger_controller.sv
test/trigger_controller_sva.sv
test/tb_trigger_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the trigger controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_trigger_controller -f tb.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
